/* hdl/mem_data_ram.sv */
// ========================================
// local data ram
// byte-writable word array
// fixed latency access fsm, rvalid/wready pulses
// ========================================

`timescale 1ns/1ps

module mem_data_ram import mem_stage_pkg::*; #(
    parameter int access_latency = 2,
    parameter int ram_words      = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     op_valid,
    input  logic     read_en,
    input  logic     write_en,
    input  word_t    addr,
    input  byte_en_t byte_en,
    input  word_t    lane_data,
    output word_t    raw_word,
    output logic     rvalid,
    output logic     wready
);

    localparam int idx_w = $clog2(ram_words);
    localparam int cnt_w = (access_latency > 1) ? $clog2(access_latency) : 1;

    word_t             mem [ram_words];
    word_t             raw_q;
    ram_state_e        state;
    logic [cnt_w-1:0]  busy_cnt;
    logic              load_q;
    logic              op_present;
    logic              last_busy;
    logic              enter_done;
    logic [idx_w-1:0]  word_idx;

    assign word_idx   = addr[idx_w+1:2];
    assign op_present = op_valid && (read_en || write_en);
    assign last_busy  = (state == ram_busy) && (busy_cnt == cnt_w'(access_latency - 1));
    assign enter_done = last_busy ||
                        ((state == ram_idle) && op_present && (access_latency == 1));

    // ========================================
    // access fsm
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ram_idle;
            busy_cnt <= '0;
            load_q   <= 1'b0;
        end else begin
            case (state)
                ram_idle: begin
                    if (enter_done) begin
                        state <= ram_done;
                    end else if (op_present) begin
                        state    <= ram_busy;
                        busy_cnt <= cnt_w'(1);
                    end
                end
                ram_busy: begin
                    if (last_busy) begin
                        state <= ram_done;
                    end else begin
                        busy_cnt <= busy_cnt + 1'b1;
                    end
                end
                ram_done: state <= ram_idle;
                default:  state <= ram_idle;
            endcase
            // remember the kind of access for the done pulse
            if (enter_done) begin
                load_q <= read_en;
            end
        end
    end

    // storage and read capture at the edge into done
    always_ff @(posedge clk) begin
        if (enter_done && write_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
        if (enter_done && read_en) begin
            raw_q <= mem[word_idx];
        end
    end

    assign raw_word = raw_q;
    assign rvalid   = (state == ram_done) && load_q;
    assign wready   = (state == ram_done) && !load_q;

    // ========================================
    // checks
    // ========================================

    a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> !(read_en && write_en));

endmodule

/* hdl/mem_forward.sv */
// ========================================
// hazard and forwarding unit
// stalls while a data ram access is open
// mem then wb forwarding to ex and id segment
// ========================================

`timescale 1ns/1ps

module mem_forward import mem_stage_pkg::*; (
    input  logic     if_valid,
    input  logic     mem_busy,
    input  reg_idx_t mem_rd,
    input  csr_idx_t mem_csr_rd,
    input  logic     mem_write_gpr,
    input  logic     mem_write_csr,
    input  logic     mem_to_reg,
    input  word_t    load_data,
    input  word_t    alu_out,
    input  word_t    csr_out,
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  csr_idx_t ex_csr_rs,
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  csr_idx_t id_csr_rs,
    input  reg_idx_t wb_rd,
    input  csr_idx_t wb_csr_rd,
    input  logic     wb_write_gpr,
    input  logic     wb_write_csr,
    input  word_t    wb_gpr_data,
    input  word_t    wb_csr_data,
    output logic     stall_if,
    output logic     stall_id,
    output logic     stall_ex,
    output logic     stall_me,
    output word_t    fwd_rs1_data_ex,
    output word_t    fwd_rs2_data_ex,
    output word_t    fwd_csr_data_ex,
    output logic     fwd_rs1_hit_ex,
    output logic     fwd_rs2_hit_ex,
    output logic     fwd_csr_hit_ex,
    output word_t    fwd_rs1_data_id,
    output word_t    fwd_rs2_data_id,
    output word_t    fwd_csr_data_id,
    output logic     fwd_rs1_hit_id,
    output logic     fwd_rs2_hit_id,
    output logic     fwd_csr_hit_id
);

    word_t mem_val;

    // ========================================
    // stalls
    // ========================================

    assign stall_if = mem_busy && if_valid;
    assign stall_id = mem_busy;
    assign stall_ex = mem_busy;
    assign stall_me = mem_busy;

    // loaded data for a load, alu result otherwise
    assign mem_val = mem_to_reg ? load_data : alu_out;

    // ========================================
    // lookups, mem stage before writeback
    // ========================================

    function automatic logic gpr_hit(input reg_idx_t rs);
        logic m_hit;
        logic w_hit;
        m_hit = mem_write_gpr && (mem_rd == rs);
        w_hit = wb_write_gpr && (wb_rd == rs);
        return (rs != '0) && (m_hit || w_hit);
    endfunction

    function automatic word_t gpr_val(input reg_idx_t rs);
        if (mem_write_gpr && (mem_rd == rs)) begin
            return mem_val;
        end
        if (wb_write_gpr && (wb_rd == rs)) begin
            return wb_gpr_data;
        end
        return '0;
    endfunction

    function automatic logic csr_hit(input csr_idx_t rs);
        return (mem_write_csr && (mem_csr_rd == rs)) ||
               (wb_write_csr && (wb_csr_rd == rs));
    endfunction

    function automatic word_t csr_val(input csr_idx_t rs);
        if (mem_write_csr && (mem_csr_rd == rs)) begin
            return csr_out;
        end
        if (wb_write_csr && (wb_csr_rd == rs)) begin
            return wb_csr_data;
        end
        return '0;
    endfunction

    always_comb begin
        fwd_rs1_hit_ex  = gpr_hit(ex_rs1);
        fwd_rs1_data_ex = gpr_val(ex_rs1);
        fwd_rs2_hit_ex  = gpr_hit(ex_rs2);
        fwd_rs2_data_ex = gpr_val(ex_rs2);
        fwd_csr_hit_ex  = csr_hit(ex_csr_rs);
        fwd_csr_data_ex = csr_val(ex_csr_rs);

        fwd_rs1_hit_id  = gpr_hit(id_rs1);
        fwd_rs1_data_id = gpr_val(id_rs1);
        fwd_rs2_hit_id  = gpr_hit(id_rs2);
        fwd_rs2_data_id = gpr_val(id_rs2);
        fwd_csr_hit_id  = csr_hit(id_csr_rs);
        fwd_csr_data_id = csr_val(id_csr_rs);
    end

endmodule

/* hdl/mem_lsu_align.sv */
// ========================================
// load/store lane alignment
// store lane steering and byte enables
// load extraction with sign/zero extension
// ========================================

`timescale 1ns/1ps

module mem_lsu_align import mem_stage_pkg::*; (
    input  access_size_e size,
    input  logic         load_unsigned,
    input  word_t        addr,
    input  word_t        store_data,
    input  word_t        raw_word,
    output byte_en_t     byte_en,
    output word_t        lane_data,
    output word_t        load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       shifted;

    // ========================================
    // store side
    // ========================================

    always_comb begin
        case (size)
            size_byte: begin
                lane_data = {4{store_data[7:0]}};
                byte_en   = byte_en_t'(4'b0001 << addr[1:0]);
            end
            size_half: begin
                lane_data = {2{store_data[15:0]}};
                byte_en   = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_data = store_data;
                byte_en   = 4'b1111;
            end
        endcase
    end

    // ========================================
    // load side
    // ========================================

    // move the addressed byte down to lane 0
    assign shifted   = raw_word >> {addr[1:0], 3'b000};
    assign load_byte = shifted[7:0];
    assign load_half = addr[1] ? raw_word[31:16] : raw_word[15:0];

    always_comb begin
        case (size)
            size_byte: begin
                load_data = load_unsigned ? {24'h0, load_byte}
                                          : {{24{load_byte[7]}}, load_byte};
            end
            size_half: begin
                load_data = load_unsigned ? {16'h0, load_half}
                                          : {{16{load_half[15]}}, load_half};
            end
            default: begin
                load_data = raw_word;
            end
        endcase
    end

    // alignment of sub-word and word accesses
    always_comb begin
        if (size == size_half) begin
            assert (addr[0] == 1'b0)
                else $error("half access not 2-byte aligned: %h", addr);
        end
        if (size == size_word) begin
            assert (addr[1:0] == 2'b00)
                else $error("word access not 4-byte aligned: %h", addr);
        end
    end

endmodule

/* hdl/mem_stage_pkg.sv */
// ========================================
// shared types for the memory stage
// word, register index, csr index, byte mask
// access size and data ram state enums
// ========================================

package mem_stage_pkg;

    // ========================================
    // plain vector types
    // ========================================

    // data or address word
    typedef logic [31:0] word_t;

    // general register index, x0 never forwards
    typedef logic [4:0]  reg_idx_t;

    // short csr index, all four values are real registers
    typedef logic [1:0]  csr_idx_t;

    // one bit per byte lane
    typedef logic [3:0]  byte_en_t;

    // ========================================
    // enums
    // ========================================

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        ram_idle = 2'd0,
        ram_busy = 2'd1,
        ram_done = 2'd2
    } ram_state_e;

endpackage

/* hdl/mem_stage_top.sv */
// ========================================
// memory stage top
// segment passthrough to writeback
// size decode, valid masking under stall
// align, data ram and forwarding blocks
// ========================================

`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; #(
    parameter int access_latency = 2,
    parameter int ram_words      = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    // execute/memory segment
    input  logic     em_commit,
    input  word_t    em_pc,
    input  word_t    em_inst,
    input  word_t    em_alu_out,
    input  word_t    em_csr_out,
    input  word_t    em_rs2_data,
    input  reg_idx_t em_rd,
    input  csr_idx_t em_csr_rd,
    input  logic     em_write_gpr,
    input  logic     em_write_csr,
    input  logic     em_mem_to_reg,
    input  logic     em_write_mem,
    input  logic     em_mem_byte,
    input  logic     em_mem_half,
    input  logic     em_mem_word,
    input  logic     em_mem_byte_u,
    input  logic     em_mem_half_u,
    input  logic     em_system_halt,
    input  logic     em_op_valid,
    input  logic     em_alu_valid,
    // hazard sources
    input  logic     if_valid,
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  csr_idx_t id_csr_rs,
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  csr_idx_t ex_csr_rs,
    // writeback sources
    input  reg_idx_t wb_rd,
    input  csr_idx_t wb_csr_rd,
    input  logic     wb_write_gpr,
    input  logic     wb_write_csr,
    input  word_t    wb_gpr_data,
    input  word_t    wb_csr_data,
    // toward writeback
    output logic     ms_commit,
    output word_t    ms_pc,
    output word_t    ms_inst,
    output word_t    ms_alu_out,
    output word_t    ms_csr_out,
    output word_t    ms_rdata,
    output logic     ms_write_gpr,
    output logic     ms_write_csr,
    output logic     ms_mem_to_reg,
    output reg_idx_t ms_rd,
    output csr_idx_t ms_csr_rd,
    output logic     ms_system_halt,
    output logic     ms_op_valid,
    output logic     ms_alu_valid,
    // stalls and forwarding
    output logic     stall_if,
    output logic     stall_id,
    output logic     stall_ex,
    output logic     stall_me,
    output word_t    fwd_rs1_data_ex,
    output word_t    fwd_rs2_data_ex,
    output word_t    fwd_csr_data_ex,
    output logic     fwd_rs1_hit_ex,
    output logic     fwd_rs2_hit_ex,
    output logic     fwd_csr_hit_ex,
    output word_t    fwd_rs1_data_id,
    output word_t    fwd_rs2_data_id,
    output word_t    fwd_csr_data_id,
    output logic     fwd_rs1_hit_id,
    output logic     fwd_rs2_hit_id,
    output logic     fwd_csr_hit_id
);

    access_size_e size;
    logic         load_unsigned;
    logic         mem_op;
    logic         mem_busy;
    logic         rvalid;
    logic         wready;
    byte_en_t     byte_en;
    word_t        lane_data;
    word_t        raw_word;
    word_t        load_data;

    assign mem_op        = em_op_valid && (em_mem_to_reg || em_write_mem);
    assign mem_busy      = mem_op && !(rvalid || wready);
    assign load_unsigned = em_mem_byte_u || em_mem_half_u;

    // one-hot strobes to size, byte while no access is present
    always_comb begin
        if (!mem_op) begin
            size = size_byte;
        end else if (em_mem_half || em_mem_half_u) begin
            size = size_half;
        end else if (em_mem_word) begin
            size = size_word;
        end else begin
            size = size_byte;
        end
    end

    // ========================================
    // passthrough to writeback
    // ========================================

    assign ms_commit      = em_commit;
    assign ms_pc          = em_pc;
    assign ms_inst        = em_inst;
    assign ms_alu_out     = em_alu_out;
    assign ms_csr_out     = em_csr_out;
    assign ms_rdata       = load_data;
    assign ms_write_gpr   = em_write_gpr;
    assign ms_write_csr   = em_write_csr;
    assign ms_mem_to_reg  = em_mem_to_reg;
    assign ms_rd          = em_rd;
    assign ms_csr_rd      = em_csr_rd;
    assign ms_system_halt = em_system_halt;
    assign ms_alu_valid   = em_alu_valid;
    // op is not handed on while the access is still open
    assign ms_op_valid    = em_op_valid && !stall_me;

    // ========================================
    // blocks
    // ========================================

    mem_lsu_align u_align (
        .size          (size),
        .load_unsigned (load_unsigned),
        .addr          (em_alu_out),
        .store_data    (em_rs2_data),
        .raw_word      (raw_word),
        .byte_en       (byte_en),
        .lane_data     (lane_data),
        .load_data     (load_data)
    );

    mem_data_ram #(
        .access_latency (access_latency),
        .ram_words      (ram_words)
    ) u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (em_op_valid),
        .read_en   (em_mem_to_reg),
        .write_en  (em_write_mem),
        .addr      (em_alu_out),
        .byte_en   (byte_en),
        .lane_data (lane_data),
        .raw_word  (raw_word),
        .rvalid    (rvalid),
        .wready    (wready)
    );

    mem_forward u_forward (
        .if_valid        (if_valid),
        .mem_busy        (mem_busy),
        .mem_rd          (em_rd),
        .mem_csr_rd      (em_csr_rd),
        .mem_write_gpr   (em_write_gpr),
        .mem_write_csr   (em_write_csr),
        .mem_to_reg      (em_mem_to_reg),
        .load_data       (load_data),
        .alu_out         (em_alu_out),
        .csr_out         (em_csr_out),
        .ex_rs1          (ex_rs1),
        .ex_rs2          (ex_rs2),
        .ex_csr_rs       (ex_csr_rs),
        .id_rs1          (id_rs1),
        .id_rs2          (id_rs2),
        .id_csr_rs       (id_csr_rs),
        .wb_rd           (wb_rd),
        .wb_csr_rd       (wb_csr_rd),
        .wb_write_gpr    (wb_write_gpr),
        .wb_write_csr    (wb_write_csr),
        .wb_gpr_data     (wb_gpr_data),
        .wb_csr_data     (wb_csr_data),
        .stall_if        (stall_if),
        .stall_id        (stall_id),
        .stall_ex        (stall_ex),
        .stall_me        (stall_me),
        .fwd_rs1_data_ex (fwd_rs1_data_ex),
        .fwd_rs2_data_ex (fwd_rs2_data_ex),
        .fwd_csr_data_ex (fwd_csr_data_ex),
        .fwd_rs1_hit_ex  (fwd_rs1_hit_ex),
        .fwd_rs2_hit_ex  (fwd_rs2_hit_ex),
        .fwd_csr_hit_ex  (fwd_csr_hit_ex),
        .fwd_rs1_data_id (fwd_rs1_data_id),
        .fwd_rs2_data_id (fwd_rs2_data_id),
        .fwd_csr_data_id (fwd_csr_data_id),
        .fwd_rs1_hit_id  (fwd_rs1_hit_id),
        .fwd_rs2_hit_id  (fwd_rs2_hit_id),
        .fwd_csr_hit_id  (fwd_csr_hit_id)
    );

endmodule

/* mem_stage.f */
hdl/mem_stage_pkg.sv
hdl/mem_lsu_align.sv
hdl/mem_data_ram.sv
hdl/mem_forward.sv
hdl/mem_stage_top.sv
tb/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the memory stage testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f mem_stage.f --top-module tb_mem_stage -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_stage 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

/* tb/tb_mem_stage.sv */
// ========================================
// testbench for the memory stage top
// clock, reset, byte model of the data ram
// compare task and directed tests
// ========================================

`timescale 1ns/1ps

module tb_mem_stage import mem_stage_pkg::*; ();

    localparam int access_latency = 2;
    localparam int ram_words      = 256;
    localparam int timeout_cycles = 16;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     em_commit;
    word_t    em_pc, em_inst, em_alu_out, em_csr_out, em_rs2_data;
    reg_idx_t em_rd;
    csr_idx_t em_csr_rd;
    logic     em_write_gpr, em_write_csr, em_mem_to_reg, em_write_mem;
    logic     em_mem_byte, em_mem_half, em_mem_word, em_mem_byte_u, em_mem_half_u;
    logic     em_system_halt, em_op_valid, em_alu_valid;
    logic     if_valid;
    reg_idx_t id_rs1, id_rs2, ex_rs1, ex_rs2;
    csr_idx_t id_csr_rs, ex_csr_rs;
    reg_idx_t wb_rd;
    csr_idx_t wb_csr_rd;
    logic     wb_write_gpr, wb_write_csr;
    word_t    wb_gpr_data, wb_csr_data;

    logic     ms_commit, ms_write_gpr, ms_write_csr, ms_mem_to_reg;
    logic     ms_system_halt, ms_op_valid, ms_alu_valid;
    word_t    ms_pc, ms_inst, ms_alu_out, ms_csr_out, ms_rdata;
    reg_idx_t ms_rd;
    csr_idx_t ms_csr_rd;
    logic     stall_if, stall_id, stall_ex, stall_me;
    word_t    fwd_rs1_data_ex, fwd_rs2_data_ex, fwd_csr_data_ex;
    word_t    fwd_rs1_data_id, fwd_rs2_data_id, fwd_csr_data_id;
    logic     fwd_rs1_hit_ex, fwd_rs2_hit_ex, fwd_csr_hit_ex;
    logic     fwd_rs1_hit_id, fwd_rs2_hit_id, fwd_csr_hit_id;

    // byte model of the data ram
    logic [7:0]  model [ram_words*4];
    string       test_name;

    always #2 clk = ~clk;

    mem_stage_top #(
        .access_latency (access_latency),
        .ram_words      (ram_words)
    ) u_dut (.*);

    // ========================================
    // helpers
    // ========================================

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("mismatch in %s, %s: expected %h actual %h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic clear_segment();
        em_commit      = 1'b0;
        em_pc          = '0;
        em_inst        = '0;
        em_alu_out     = '0;
        em_csr_out     = '0;
        em_rs2_data    = '0;
        em_rd          = '0;
        em_csr_rd      = '0;
        em_write_gpr   = 1'b0;
        em_write_csr   = 1'b0;
        em_mem_to_reg  = 1'b0;
        em_write_mem   = 1'b0;
        em_mem_byte    = 1'b0;
        em_mem_half    = 1'b0;
        em_mem_word    = 1'b0;
        em_mem_byte_u  = 1'b0;
        em_mem_half_u  = 1'b0;
        em_system_halt = 1'b0;
        em_op_valid    = 1'b0;
        em_alu_valid   = 1'b0;
        if_valid       = 1'b1;
        id_rs1         = '0;
        id_rs2         = '0;
        id_csr_rs      = '0;
        ex_rs1         = '0;
        ex_rs2         = '0;
        ex_csr_rs      = '0;
        wb_rd          = '0;
        wb_csr_rd      = '0;
        wb_write_gpr   = 1'b0;
        wb_write_csr   = 1'b0;
        wb_gpr_data    = '0;
        wb_csr_data    = '0;
    endtask

    task automatic check_stalls(input logic expected);
        check_value("stall_if", word_t'(expected), word_t'(stall_if));
        check_value("stall_id", word_t'(expected), word_t'(stall_id));
        check_value("stall_ex", word_t'(expected), word_t'(stall_ex));
        check_value("stall_me", word_t'(expected), word_t'(stall_me));
    endtask

    // load result built from the model bytes, little endian
    function automatic word_t expected_load(input word_t addr, input int sz, input logic uns);
        int          a;
        logic [7:0]  b;
        logic [15:0] h;
        a = int'(addr);
        if (sz == 4) begin
            return {model[a+3], model[a+2], model[a+1], model[a]};
        end
        if (sz == 2) begin
            h = {model[a+1], model[a]};
            return uns ? {16'h0, h} : {{16{h[15]}}, h};
        end
        b = model[a];
        return uns ? {24'h0, b} : {{24{b[7]}}, b};
    endfunction

    task automatic update_model(input word_t addr, input int sz, input word_t data);
        for (int i = 0; i < sz; i++) begin
            model[int'(addr) + i] = data[8*i +: 8];
        end
    endtask

    // one load or store, waits for the stall to drop
    task automatic mem_access(input logic is_load, input int sz, input logic uns,
                              input word_t addr, input word_t data, input reg_idx_t rd);
        int    cycles;
        logic  done;
        word_t expected;
        cycles = 0;
        done   = 1'b0;
        @(negedge clk);
        em_op_valid   = 1'b1;
        em_mem_to_reg = is_load;
        em_write_mem  = !is_load;
        em_write_gpr  = is_load;
        em_rd         = rd;
        ex_rs1        = rd;
        em_alu_out    = addr;
        em_rs2_data   = data;
        em_mem_byte   = (sz == 1) && !uns;
        em_mem_byte_u = (sz == 1) && uns;
        em_mem_half   = (sz == 2) && !uns;
        em_mem_half_u = (sz == 2) && uns;
        em_mem_word   = (sz == 4);
        while (!done) begin
            #1;
            if (!stall_me) begin
                done = 1'b1;
            end else begin
                check_stalls(1'b1);
                check_value("ms_op_valid while stalled", '0, word_t'(ms_op_valid));
                cycles++;
                if (cycles > timeout_cycles) begin
                    $display("timeout in %s: the memory access never completed", test_name);
                    abort_run();
                end
                @(negedge clk);
            end
        end
        check_value("stall cycles", word_t'(access_latency), word_t'(cycles));
        check_stalls(1'b0);
        check_value("ms_op_valid on completion", 32'd1, word_t'(ms_op_valid));
        check_value("ms_mem_to_reg", word_t'(is_load), word_t'(ms_mem_to_reg));
        if (is_load) begin
            expected = expected_load(addr, sz, uns);
            check_value("ms_rdata", expected, ms_rdata);
            if (rd != '0) begin
                check_value("fwd_rs1_data_ex", expected, fwd_rs1_data_ex);
                check_value("fwd_rs1_hit_ex", 32'd1, word_t'(fwd_rs1_hit_ex));
            end else begin
                check_value("fwd_rs1_hit_ex for x0", '0, word_t'(fwd_rs1_hit_ex));
            end
        end else begin
            update_model(addr, sz, data);
        end
        @(negedge clk);
        clear_segment();
    endtask

    // ========================================
    // directed tests
    // ========================================

    task automatic test_reset_passthrough();
        test_name = "reset_passthrough";
        @(negedge clk);
        #1;
        check_stalls(1'b0);
        repeat (4) begin
            @(negedge clk);
            em_commit      = 1'($urandom_range(0, 1));
            em_pc          = $urandom;
            em_inst        = $urandom;
            em_alu_out     = $urandom;
            em_csr_out     = $urandom;
            em_rs2_data    = $urandom;
            em_rd          = reg_idx_t'($urandom);
            em_csr_rd      = csr_idx_t'($urandom);
            em_write_gpr   = 1'($urandom_range(0, 1));
            em_write_csr   = 1'($urandom_range(0, 1));
            em_system_halt = 1'($urandom_range(0, 1));
            em_alu_valid   = 1'($urandom_range(0, 1));
            em_op_valid    = 1'b1;
            #1;
            check_stalls(1'b0);
            check_value("ms_commit", word_t'(em_commit), word_t'(ms_commit));
            check_value("ms_pc", em_pc, ms_pc);
            check_value("ms_inst", em_inst, ms_inst);
            check_value("ms_alu_out", em_alu_out, ms_alu_out);
            check_value("ms_csr_out", em_csr_out, ms_csr_out);
            check_value("ms_rd", word_t'(em_rd), word_t'(ms_rd));
            check_value("ms_csr_rd", word_t'(em_csr_rd), word_t'(ms_csr_rd));
            check_value("ms_write_gpr", word_t'(em_write_gpr), word_t'(ms_write_gpr));
            check_value("ms_write_csr", word_t'(em_write_csr), word_t'(ms_write_csr));
            check_value("ms_mem_to_reg", '0, word_t'(ms_mem_to_reg));
            check_value("ms_system_halt", word_t'(em_system_halt), word_t'(ms_system_halt));
            check_value("ms_alu_valid", word_t'(em_alu_valid), word_t'(ms_alu_valid));
            check_value("ms_op_valid", 32'd1, word_t'(ms_op_valid));
        end
        @(negedge clk);
        clear_segment();
    endtask

    task automatic test_word_round_trip();
        word_t addrs[$];
        word_t a;
        test_name = "word_round_trip";
        for (int i = 0; i < 8; i++) begin
            a = word_t'($urandom_range(0, ram_words - 1)) << 2;
            addrs.push_back(a);
            mem_access(1'b0, 4, 1'b0, a, $urandom, '0);
        end
        foreach (addrs[i]) begin
            mem_access(1'b1, 4, 1'b0, addrs[i], '0, '0);
        end
    endtask

    task automatic test_sub_word();
        word_t base;
        test_name = "sub_word";
        base = word_t'($urandom_range(0, ram_words - 4)) << 2;
        // fixed word so both extension kinds show up
        mem_access(1'b0, 4, 1'b0, base, 32'h80ff_7f01, '0);
        for (int i = 1; i < 4; i++) begin
            mem_access(1'b0, 4, 1'b0, base + 4*i, $urandom, '0);
        end
        for (int i = 0; i < 4; i++) begin
            mem_access(1'b0, 1, 1'b0, base + $urandom_range(0, 15), $urandom, '0);
            mem_access(1'b0, 2, 1'b0, base + ($urandom_range(0, 7) << 1), $urandom, '0);
        end
        for (int off = 0; off < 16; off++) begin
            mem_access(1'b1, 1, 1'b0, base + off, '0, '0);
            mem_access(1'b1, 1, 1'b1, base + off, '0, '0);
            if (off % 2 == 0) begin
                mem_access(1'b1, 2, 1'b0, base + off, '0, '0);
                mem_access(1'b1, 2, 1'b1, base + off, '0, '0);
            end
        end
    endtask

    task automatic check_gpr_fwd(input logic hit, input word_t expected);
        check_value("fwd_rs1_hit_ex", word_t'(hit), word_t'(fwd_rs1_hit_ex));
        check_value("fwd_rs2_hit_ex", word_t'(hit), word_t'(fwd_rs2_hit_ex));
        check_value("fwd_rs1_hit_id", word_t'(hit), word_t'(fwd_rs1_hit_id));
        check_value("fwd_rs2_hit_id", word_t'(hit), word_t'(fwd_rs2_hit_id));
        if (hit) begin
            check_value("fwd_rs1_data_ex", expected, fwd_rs1_data_ex);
            check_value("fwd_rs2_data_ex", expected, fwd_rs2_data_ex);
            check_value("fwd_rs1_data_id", expected, fwd_rs1_data_id);
            check_value("fwd_rs2_data_id", expected, fwd_rs2_data_id);
        end
    endtask

    task automatic check_csr_fwd(input word_t expected);
        check_value("fwd_csr_hit_ex", 32'd1, word_t'(fwd_csr_hit_ex));
        check_value("fwd_csr_hit_id", 32'd1, word_t'(fwd_csr_hit_id));
        check_value("fwd_csr_data_ex", expected, fwd_csr_data_ex);
        check_value("fwd_csr_data_id", expected, fwd_csr_data_id);
    endtask

    task automatic test_forwarding();
        reg_idx_t r;
        test_name = "forwarding";
        r = reg_idx_t'($urandom_range(2, 31));
        @(negedge clk);
        em_alu_out   = $urandom;
        em_csr_out   = $urandom;
        wb_gpr_data  = $urandom;
        wb_csr_data  = $urandom;
        em_rd        = r;
        em_write_gpr = 1'b1;
        wb_rd        = r;
        wb_write_gpr = 1'b1;
        ex_rs1       = r;
        ex_rs2       = r;
        id_rs1       = r;
        id_rs2       = r;
        #1;
        check_gpr_fwd(1'b1, em_alu_out);
        // writeback only
        @(negedge clk);
        em_rd = r ^ 5'd1;
        #1;
        check_gpr_fwd(1'b1, wb_gpr_data);
        // x0 from both sources
        @(negedge clk);
        em_rd  = '0;
        wb_rd  = '0;
        ex_rs1 = '0;
        ex_rs2 = '0;
        id_rs1 = '0;
        id_rs2 = '0;
        #1;
        check_gpr_fwd(1'b0, '0);
        // csr index 0 is a real register
        @(negedge clk);
        em_csr_rd    = '0;
        em_write_csr = 1'b1;
        wb_csr_rd    = '0;
        wb_write_csr = 1'b1;
        ex_csr_rs    = '0;
        id_csr_rs    = '0;
        #1;
        check_csr_fwd(em_csr_out);
        @(negedge clk);
        em_csr_rd = 2'd1;
        #1;
        check_csr_fwd(wb_csr_data);
        @(negedge clk);
        clear_segment();
    endtask

    task automatic test_load_use();
        word_t    a;
        reg_idx_t rd;
        test_name = "load_use";
        for (int i = 0; i < 4; i++) begin
            a  = word_t'($urandom_range(0, ram_words - 1)) << 2;
            rd = reg_idx_t'($urandom_range(1, 31));
            mem_access(1'b0, 4, 1'b0, a, $urandom, '0);
            mem_access(1'b1, 4, 1'b0, a, '0, rd);
            mem_access(1'b1, 1, 1'b0, a + $urandom_range(0, 3), '0, rd);
        end
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        void'($urandom(54));
        rst_n = 1'b0;
        clear_segment();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_passthrough();
        test_word_round_trip();
        test_sub_word();
        test_forwarding();
        test_load_use();
        $display("TEST PASS");
        $finish;
    end

endmodule
